//--- logic/IssueQueue.sv
// ##############################
// Issue queue
// Entry state, lowest-free allocation,
// release and selective flush
// ##############################

module IssueQueue (
    input  logic clk,
    input  logic arstN,
    input  logic stall,
    input  SchedulerTypes::DispatchOp dispatch,
    input  RecoveryTypes::FlushRequest flush,
    input  SchedulerTypes::IssueOp selected [SchedulerTypes::LANE_COUNT],
    input  SchedulerTypes::WakeupOp wakeup [SchedulerTypes::LANE_COUNT],
    input  logic releaseEntry [SchedulerTypes::LANE_COUNT],
    input  SchedulerTypes::IqIndex releasePtr [SchedulerTypes::LANE_COUNT],
    output SchedulerTypes::IqOneHot candidates [SchedulerTypes::LANE_COUNT],
    output RecoveryTypes::ActiveListIndex entryAlPtr [SchedulerTypes::IQ_DEPTH],
    output SchedulerTypes::IqIndex dispatchPtr,
    output logic full
);
    import SchedulerTypes::*;
    import RecoveryTypes::*;

    IqOneHot entryValid;
    IqOneHot entryIssued;
    IssueLane entryLane [IQ_DEPTH];
    IqOneHot ready;
    IqOneHot wakeupVector;
    logic writeEnable;

    // Lowest free entry, zero when the queue is full
    always_comb begin
        dispatchPtr = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!entryValid[i]) begin
                dispatchPtr = IqIndex'(i);
            end
        end
    end

    assign full = &entryValid;
    assign writeEnable = dispatch.valid && !full && !stall;

    // Merge the producer columns of both lanes
    always_comb begin
        wakeupVector = '0;
        for (int l = 0; l < LANE_COUNT; l++) begin
            if (wakeup[l].valid) begin
                wakeupVector = wakeupVector | wakeup[l].vector;
            end
        end
    end

    ProducerMatrix matrix (
        .clk(clk),
        .arstN(arstN),
        .writeEnable(writeEnable),
        .writePtr(dispatchPtr),
        .writeVector(dispatch.depVector),
        .wakeupVector(wakeupVector),
        .ready(ready)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            entryValid <= '0;
            entryIssued <= '0;
        end else begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (flush.valid && entryValid[i] &&
                    InFlushRange(flush.all, flush.headPtr, flush.tailPtr, entryAlPtr[i])) begin
                    entryValid[i] <= 1'b0;
                end
            end
            for (int l = 0; l < LANE_COUNT; l++) begin
                if (releaseEntry[l]) begin
                    entryValid[releasePtr[l]] <= 1'b0;
                end
                if (selected[l].valid) begin
                    entryIssued[selected[l].ptr] <= 1'b1;
                end
            end
            // The free entry being written is never flushed or released
            if (writeEnable) begin
                entryValid[dispatchPtr] <= 1'b1;
                entryIssued[dispatchPtr] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            entryLane[dispatchPtr] <= dispatch.lane;
            entryAlPtr[dispatchPtr] <= dispatch.activeListPtr;
        end
    end

    // Valid, waiting, ready ops of each lane
    always_comb begin
        for (int l = 0; l < LANE_COUNT; l++) begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                candidates[l][i] = entryValid[i] && !entryIssued[i] && ready[i] &&
                                   (entryLane[i] == IssueLane'(l));
            end
        end
    end

endmodule

//--- logic/ProducerMatrix.sv
// ##############################
// Producer matrix
// Dependency rows and ready vector
// ##############################

module ProducerMatrix (
    input  logic clk,
    input  logic arstN,
    input  logic writeEnable,
    input  SchedulerTypes::IqIndex writePtr,
    input  SchedulerTypes::IqOneHot writeVector,
    input  SchedulerTypes::IqOneHot wakeupVector,
    output SchedulerTypes::IqOneHot ready
);
    import SchedulerTypes::*;

    // One row per entry, a set bit is a producer still outstanding
    IqOneHot depRow [IQ_DEPTH];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                depRow[i] <= '0;
            end
        end else begin
            // Clear the producer's column in every row
            for (int i = 0; i < IQ_DEPTH; i++) begin
                depRow[i] <= depRow[i] & ~wakeupVector;
            end
            // New op skips producers that wake up this very cycle
            if (writeEnable) begin
                depRow[writePtr] <= writeVector & ~wakeupVector;
            end
        end
    end

    // Entry is ready once its row is empty
    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            ready[i] = (depRow[i] == '0);
        end
    end

endmodule

//--- logic/RecoveryTypes.sv
// ##############################
// Recovery types
// Active-list pointer, flush request
// and the flush range test
// ##############################

package RecoveryTypes;

    // Active-list position of a micro-op
    typedef logic [4:0] ActiveListIndex;

    // Selective flush over an active-list range
    typedef struct packed {
        logic valid;
        logic all;
        ActiveListIndex headPtr;
        ActiveListIndex tailPtr;
    } FlushRequest;

    // True for ptr in [headPtr, tailPtr) with wraparound, or when all is set
    function automatic logic InFlushRange(
        input logic all,
        input ActiveListIndex headPtr,
        input ActiveListIndex tailPtr,
        input ActiveListIndex ptr
    );
        logic inRange;
        if (headPtr <= tailPtr) begin
            inRange = (ptr >= headPtr) && (ptr < tailPtr);
        end else begin
            // Range wraps past the end of the active list
            inRange = (ptr >= headPtr) || (ptr < tailPtr);
        end
        return all || inRange;
    endfunction

endpackage

//--- logic/Scheduler.sv
// ##############################
// Scheduler top level
// Queue, select and wakeup pipe
// ##############################

module Scheduler (
    input  logic clk,
    input  logic arstN,
    input  logic stall,
    input  SchedulerTypes::DispatchOp dispatch,
    input  RecoveryTypes::FlushRequest flush,
    output SchedulerTypes::IssueOp issue [SchedulerTypes::LANE_COUNT],
    output SchedulerTypes::WakeupOp wakeup [SchedulerTypes::LANE_COUNT],
    output SchedulerTypes::IqIndex dispatchPtr,
    output logic full
);
    import SchedulerTypes::*;
    import RecoveryTypes::*;

    IqOneHot candidates [LANE_COUNT];
    ActiveListIndex entryAlPtr [IQ_DEPTH];
    logic releaseEntry [LANE_COUNT];
    IqIndex releasePtr [LANE_COUNT];

    IssueQueue queue (
        .clk(clk),
        .arstN(arstN),
        .stall(stall),
        .dispatch(dispatch),
        .flush(flush),
        .selected(issue),
        .wakeup(wakeup),
        .releaseEntry(releaseEntry),
        .releasePtr(releasePtr),
        .candidates(candidates),
        .entryAlPtr(entryAlPtr),
        .dispatchPtr(dispatchPtr),
        .full(full)
    );

    // Selected ops are the issue output
    SelectLogic select (
        .candidates(candidates),
        .entryAlPtr(entryAlPtr),
        .stall(stall),
        .selected(issue)
    );

    WakeupPipelineRegister wakeupPipe (
        .clk(clk),
        .arstN(arstN),
        .stall(stall),
        .selected(issue),
        .flush(flush),
        .wakeup(wakeup),
        .releaseEntry(releaseEntry),
        .releasePtr(releasePtr)
    );

endmodule

//--- logic/SchedulerTypes.sv
// ##############################
// Scheduler types
// Queue sizes, lanes, latencies and
// dispatch, issue and wakeup structs
// ##############################

package SchedulerTypes;

    localparam int IQ_DEPTH = 8;
    localparam int LANE_COUNT = 2;

    // Cycles from issue to wakeup per lane
    localparam int INT_LATENCY = 1;
    localparam int MEM_LATENCY = 2;

    typedef logic [$clog2(IQ_DEPTH)-1:0] IqIndex;
    typedef logic [IQ_DEPTH-1:0] IqOneHot;

    // Wide enough for the longest lane latency
    typedef logic [$clog2(MEM_LATENCY):0] FlushCount;

    typedef enum logic {
        LANE_INT = 1'b0,
        LANE_MEM = 1'b1
    } IssueLane;

    // Op written by the dispatcher
    typedef struct packed {
        logic valid;
        IssueLane lane;
        RecoveryTypes::ActiveListIndex activeListPtr;
        IqOneHot depVector;
    } DispatchOp;

    // Op picked by select, one per lane
    typedef struct packed {
        logic valid;
        IqIndex ptr;
        RecoveryTypes::ActiveListIndex activeListPtr;
    } IssueOp;

    // Producer leaving the wakeup pipe
    typedef struct packed {
        logic valid;
        IqIndex ptr;
        IqOneHot vector;
    } WakeupOp;

endpackage

//--- logic/SelectLogic.sv
// ##############################
// Select logic
// Lowest-index pick per lane
// ##############################

module SelectLogic (
    input  SchedulerTypes::IqOneHot candidates [SchedulerTypes::LANE_COUNT],
    input  RecoveryTypes::ActiveListIndex entryAlPtr [SchedulerTypes::IQ_DEPTH],
    input  logic stall,
    output SchedulerTypes::IssueOp selected [SchedulerTypes::LANE_COUNT]
);
    import SchedulerTypes::*;

    always_comb begin
        for (int l = 0; l < LANE_COUNT; l++) begin
            selected[l] = '0;
            // Nothing leaves the queue while frozen
            if (!stall) begin
                // Scan downward so the lowest candidate is kept
                for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
                    if (candidates[l][i]) begin
                        selected[l].valid = 1'b1;
                        selected[l].ptr = IqIndex'(i);
                        // Needed by the flush range test in the pipe
                        selected[l].activeListPtr = entryAlPtr[i];
                    end
                end
            end
        end
    end

endmodule

//--- logic/WakeupPipelineRegister.sv
// ##############################
// Wakeup pipeline register
// Per-lane latency pipe with
// selective flush of ops in flight
// ##############################

module WakeupPipelineRegister (
    input  logic clk,
    input  logic arstN,
    input  logic stall,
    input  SchedulerTypes::IssueOp selected [SchedulerTypes::LANE_COUNT],
    input  RecoveryTypes::FlushRequest flush,
    output SchedulerTypes::WakeupOp wakeup [SchedulerTypes::LANE_COUNT],
    output logic releaseEntry [SchedulerTypes::LANE_COUNT],
    output SchedulerTypes::IqIndex releasePtr [SchedulerTypes::LANE_COUNT]
);
    import SchedulerTypes::*;
    import RecoveryTypes::*;

    // Range of the last flush, checked at the pipe outputs
    logic rangeAll;
    ActiveListIndex rangeHead;
    ActiveListIndex rangeTail;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rangeAll <= 1'b0;
            rangeHead <= '0;
            rangeTail <= '0;
        end else if (flush.valid) begin
            rangeAll <= flush.all;
            rangeHead <= flush.headPtr;
            rangeTail <= flush.tailPtr;
        end
    end

    for (genvar lane = 0; lane < LANE_COUNT; lane++) begin : gLane
        localparam int DEPTH = (lane == int'(LANE_MEM)) ? MEM_LATENCY : INT_LATENCY;

        IssueOp stage [DEPTH];
        IssueOp entering;
        FlushCount flushCount;
        logic dropped;
        logic live;

        // Op picked in the flush cycle must not enter if it is in range
        always_comb begin
            entering = selected[lane];
            if (flush.valid && InFlushRange(flush.all, flush.headPtr, flush.tailPtr,
                                            selected[lane].activeListPtr)) begin
                entering.valid = 1'b0;
            end
        end

        // Shift toward stage 0, frozen by stall
        always_ff @(posedge clk or negedge arstN) begin
            if (!arstN) begin
                for (int s = 0; s < DEPTH; s++) begin
                    stage[s] <= '0;
                end
            end else if (!stall) begin
                for (int s = 1; s < DEPTH; s++) begin
                    stage[s-1] <= stage[s];
                end
                stage[DEPTH-1] <= entering;
            end
        end

        // Stages left that may still hold cancelled ops
        always_ff @(posedge clk or negedge arstN) begin
            if (!arstN) begin
                flushCount <= '0;
            end else if (flush.valid) begin
                flushCount <= FlushCount'(DEPTH);
            end else if (flushCount != '0 && !stall) begin
                flushCount <= flushCount - 1'b1;
            end
        end

        assign dropped = (flushCount != '0) &&
                         InFlushRange(rangeAll, rangeHead, rangeTail, stage[0].activeListPtr);
        assign live = stage[0].valid && !stall && !dropped;

        assign wakeup[lane] = '{valid: live,
                                ptr: stage[0].ptr,
                                vector: IqOneHot'(1) << stage[0].ptr};
        assign releaseEntry[lane] = live;
        assign releasePtr[lane] = stage[0].ptr;
    end

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module SchedulerTb -f scheduler.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Compilation failed"
    exit 1
fi

./obj_dir/VSchedulerTb
if [ $? -ne 0 ]; then
    echo "Simulation failed"
    exit 1
fi
exit 0

//--- scheduler.f
logic/RecoveryTypes.sv
logic/SchedulerTypes.sv
logic/ProducerMatrix.sv
logic/IssueQueue.sv
logic/SelectLogic.sv
logic/WakeupPipelineRegister.sv
logic/Scheduler.sv
testbench/ClockGen.sv
testbench/SchedulerProtocol_checker.sv
testbench/SchedulerTb.sv

//--- testbench/ClockGen.sv
// ##############################
// Testbench clock, period 4
// ##############################

module ClockGen (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always begin
        #2 clk = ~clk;
    end

endmodule

//--- testbench/SchedulerProtocol_checker.sv
// ##############################
// Protocol assertions for the
// scheduler, bound into Scheduler
// ##############################

module SchedulerProtocol_checker (
    input logic clk,
    input logic arstN,
    input logic stall,
    input RecoveryTypes::FlushRequest flush,
    input SchedulerTypes::IssueOp issue [SchedulerTypes::LANE_COUNT],
    input SchedulerTypes::WakeupOp wakeup [SchedulerTypes::LANE_COUNT],
    input SchedulerTypes::IqIndex dispatchPtr,
    input logic full,
    input SchedulerTypes::IqOneHot entryValid
);
    // One entry never sits on both lanes at once
    assert property (@(posedge clk) disable iff (!arstN)
        !(issue[0].valid && issue[1].valid && issue[0].ptr == issue[1].ptr))
        else $error("Both issue lanes carry entry %0d", issue[0].ptr);

    assert property (@(posedge clk) disable iff (!arstN)
        !(wakeup[0].valid && wakeup[1].valid && wakeup[0].ptr == wakeup[1].ptr))
        else $error("Both wakeup lanes carry entry %0d", wakeup[0].ptr);

    // Frozen scheduler neither frees nor takes an entry
    assert property (@(posedge clk) disable iff (!arstN)
        stall && !flush.valid |=> entryValid == $past(entryValid))
        else $error("Entry state changed during stall");

    // Dispatch pointer sits on a busy entry only when the queue is full
    assert property (@(posedge clk) disable iff (!arstN) entryValid[dispatchPtr] == full)
        else $error("Entry %0d at dispatchPtr disagrees with full", dispatchPtr);

endmodule

bind Scheduler SchedulerProtocol_checker protocolCheck (
    .clk(clk),
    .arstN(arstN),
    .stall(stall),
    .flush(flush),
    .issue(issue),
    .wakeup(wakeup),
    .dispatchPtr(dispatchPtr),
    .full(full),
    .entryValid(queue.entryValid)
);

//--- testbench/SchedulerTb.sv
// ##############################
// Scheduler testbench
// Reference model, directed and random
// stimulus, per-cycle comparison
// ##############################

module SchedulerTb;
    import SchedulerTypes::*;
    import RecoveryTypes::*;

    // Outputs predicted for one cycle
    typedef struct packed {
        IssueOp [LANE_COUNT-1:0] issue;
        WakeupOp [LANE_COUNT-1:0] wakeup;
        IqIndex dispatchPtr;
        logic full;
    } Expected;

    logic clk;
    logic arstN;
    logic stall;
    DispatchOp dispatch;
    FlushRequest flush;
    IssueOp issue [LANE_COUNT];
    WakeupOp wakeup [LANE_COUNT];
    IqIndex dispatchPtr;
    logic full;
    int seed;
    ActiveListIndex nextAl;

    // Reference model state
    logic refValid [IQ_DEPTH];
    logic refIssued [IQ_DEPTH];
    IssueLane refLane [IQ_DEPTH];
    ActiveListIndex refAl [IQ_DEPTH];
    IqOneHot refDep [IQ_DEPTH];
    IssueOp refPipe [LANE_COUNT][MEM_LATENCY];
    FlushCount refCount [LANE_COUNT];
    FlushRequest refRange;

    ClockGen clockGen (.clk(clk));

    Scheduler DUT (
        .clk(clk),
        .arstN(arstN),
        .stall(stall),
        .dispatch(dispatch),
        .flush(flush),
        .issue(issue),
        .wakeup(wakeup),
        .dispatchPtr(dispatchPtr),
        .full(full)
    );

    function automatic void clearModel();
        for (int i = 0; i < IQ_DEPTH; i++) begin
            refValid[i] = 1'b0;
            refIssued[i] = 1'b0;
            refDep[i] = '0;
        end
        for (int l = 0; l < LANE_COUNT; l++) begin
            refCount[l] = '0;
            for (int s = 0; s < MEM_LATENCY; s++) begin
                refPipe[l][s] = '0;
            end
        end
        refRange = '0;
    endfunction

    // Distance from head modulo the active-list size
    function automatic logic inRange(input logic all, input ActiveListIndex head,
                                     input ActiveListIndex tail, input ActiveListIndex ptr);
        ActiveListIndex offset;
        ActiveListIndex span;
        offset = ptr - head;
        span = tail - head;
        return all || (offset < span);
    endfunction

    function automatic int laneDepth(input int l);
        return (l == 1) ? MEM_LATENCY : INT_LATENCY;
    endfunction

    function automatic logic modelEmpty();
        logic empty;
        empty = 1'b1;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            empty = empty && !refValid[i];
        end
        for (int s = 0; s < MEM_LATENCY; s++) begin
            empty = empty && !refPipe[0][s].valid && !refPipe[1][s].valid;
        end
        return empty;
    endfunction

    // Predicts the outputs of one cycle and advances the model to the next edge
    function automatic Expected stepModel(input logic s, input DispatchOp d,
                                          input FlushRequest f);
        Expected want;
        IqOneHot woken;
        IssueOp out;
        IssueOp enter;
        int freeIdx;
        int depth;
        want = '0;
        woken = '0;
        freeIdx = -1;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (!refValid[i] && freeIdx < 0) begin
                freeIdx = i;
            end
        end
        want.full = (freeIdx < 0);
        want.dispatchPtr = want.full ? '0 : IqIndex'(freeIdx);
        for (int l = 0; l < LANE_COUNT; l++) begin
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (!s && !want.issue[l].valid && refValid[i] && !refIssued[i] &&
                    refDep[i] == '0 && refLane[i] == IssueLane'(l)) begin
                    want.issue[l] = '{valid: 1'b1, ptr: IqIndex'(i), activeListPtr: refAl[i]};
                end
            end
            out = refPipe[l][0];
            if (out.valid && !s && !(refCount[l] != '0 &&
                inRange(refRange.all, refRange.headPtr, refRange.tailPtr, out.activeListPtr))) begin
                want.wakeup[l].valid = 1'b1;
                want.wakeup[l].ptr = out.ptr;
                want.wakeup[l].vector[out.ptr] = 1'b1;
                woken[out.ptr] = 1'b1;
            end
        end
        for (int i = 0; i < IQ_DEPTH; i++) begin
            refDep[i] = refDep[i] & ~woken;
            if (f.valid && refValid[i] && inRange(f.all, f.headPtr, f.tailPtr, refAl[i])) begin
                refValid[i] = 1'b0;
            end
        end
        for (int l = 0; l < LANE_COUNT; l++) begin
            if (want.wakeup[l].valid) begin
                refValid[want.wakeup[l].ptr] = 1'b0;
            end
            if (want.issue[l].valid) begin
                refIssued[want.issue[l].ptr] = 1'b1;
            end
        end
        if (d.valid && !s && !want.full) begin
            refValid[freeIdx] = 1'b1;
            refIssued[freeIdx] = 1'b0;
            refLane[freeIdx] = d.lane;
            refAl[freeIdx] = d.activeListPtr;
            refDep[freeIdx] = d.depVector & ~woken;
        end
        for (int l = 0; l < LANE_COUNT; l++) begin
            depth = laneDepth(l);
            if (!s) begin
                enter = want.issue[l];
                if (f.valid && inRange(f.all, f.headPtr, f.tailPtr, enter.activeListPtr)) begin
                    enter.valid = 1'b0;
                end
                for (int k = 1; k < depth; k++) begin
                    refPipe[l][k-1] = refPipe[l][k];
                end
                refPipe[l][depth-1] = enter;
            end
            if (f.valid) begin
                refCount[l] = FlushCount'(depth);
            end else if (refCount[l] != '0 && !s) begin
                refCount[l]--;
            end
        end
        if (f.valid) begin
            refRange = f;
        end
        return want;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("** Error: %s expected 0x%0h, got 0x%0h", name, expected, actual));
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin : compareOutputs
        Expected want;
        if (arstN) begin
            want = stepModel(stall, dispatch, flush);
            checkValue("full", 32'(full), 32'(want.full));
            checkValue("dispatchPtr", 32'(dispatchPtr), 32'(want.dispatchPtr));
            for (int l = 0; l < LANE_COUNT; l++) begin
                checkValue($sformatf("issue[%0d]", l), 32'(issue[l]), 32'(want.issue[l]));
                checkValue($sformatf("wakeup[%0d].valid", l), 32'(wakeup[l].valid),
                           32'(want.wakeup[l].valid));
                if (want.wakeup[l].valid) begin
                    checkValue($sformatf("wakeup[%0d]", l), 32'(wakeup[l]), 32'(want.wakeup[l]));
                end
            end
        end
    end

    task automatic driveCycle(input logic s, input DispatchOp d, input FlushRequest f);
        @(posedge clk);
        stall <= s;
        dispatch <= d;
        flush <= f;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) driveCycle(1'b0, '0, '0);
    endtask

    task automatic sendOp(input IssueLane lane, input ActiveListIndex al, input IqOneHot dep);
        DispatchOp op;
        op = '{valid: 1'b1, lane: lane, activeListPtr: al, depVector: dep};
        driveCycle(1'b0, op, '0);
    endtask

    task automatic sendFlush(input logic all, input ActiveListIndex head,
                             input ActiveListIndex tail);
        FlushRequest f;
        f = '{valid: 1'b1, all: all, headPtr: head, tailPtr: tail};
        driveCycle(1'b0, '0, f);
    endtask

    task automatic waitDrain(input int limit);
        int n;
        n = 0;
        while (!modelEmpty()) begin
            if (n == limit) begin
                abortRun("Queue and wakeup pipe did not drain in time");
            end
            idleCycles(1);
            n++;
        end
    endtask

    task automatic waitFull(input logic level, input int limit);
        int n;
        n = 0;
        idleCycles(1);
        @(negedge clk);
        while (full !== level) begin
            if (n == limit) begin
                abortRun($sformatf("Full did not reach %0d in time", level));
            end
            idleCycles(1);
            @(negedge clk);
            n++;
        end
    endtask

    // Random op with an optional dependency and an occasional stall or flush
    task automatic randomCycle();
        logic [31:0] r;
        DispatchOp op;
        FlushRequest f;
        logic s;
        // Model state here is the start of the cycle being driven
        @(posedge clk);
        r = $random(seed);
        op = '0;
        f = '0;
        s = (r[4:2] == 3'b000);
        if (r[1:0] != 2'b00 && !s && !modelEmpty() || r[1:0] == 2'b11) begin
            op.valid = 1'b1;
        end
        op.valid = op.valid && !refValid.and();
        op.lane = IssueLane'(r[26]);
        op.activeListPtr = nextAl;
        if (r[22] && refValid[r[25:23]]) begin
            op.depVector = IqOneHot'(1) << r[25:23];
        end
        // A new flush waits until the previous window has closed
        if (r[9:6] == 4'b0000 && refCount[0] == '0 && refCount[1] == '0) begin
            f = '{valid: 1'b1, all: r[10] && r[11], headPtr: r[16:12], tailPtr: r[21:17]};
        end
        if (op.valid) begin
            nextAl++;
        end
        stall <= s;
        dispatch <= op;
        flush <= f;
    endtask

    initial begin
        seed = 32'hb860_f849;
        nextAl = '0;
        arstN = 1'b0;
        stall = 1'b0;
        dispatch = '0;
        flush = '0;
        clearModel();
        repeat (10) @(posedge clk);
        arstN <= 1'b1;
        // Independent ops on both lanes
        for (int i = 0; i < 4; i++) begin
            sendOp(IssueLane'(i % 2), ActiveListIndex'(i), '0);
        end
        waitDrain(20);
        // Producer and consumer on the integer lane and then on the memory lane
        sendOp(LANE_INT, 5'd4, '0);
        sendOp(LANE_INT, 5'd5, 8'h01);
        waitDrain(20);
        sendOp(LANE_MEM, 5'd6, '0);
        sendOp(LANE_MEM, 5'd7, 8'h01);
        waitDrain(20);
        // Reverse chain holds every entry until the last op arrives
        for (int i = 0; i < IQ_DEPTH; i++) begin
            sendOp((i == IQ_DEPTH - 1) ? LANE_MEM : IssueLane'(i % 2), ActiveListIndex'(16 + i),
                   (i == IQ_DEPTH - 1) ? IqOneHot'(0) : IqOneHot'(1) << (i + 1));
        end
        waitFull(1'b1, 10);
        waitFull(1'b0, 10);
        sendOp(LANE_INT, 5'd24, '0);
        sendOp(LANE_MEM, 5'd25, '0);
        waitDrain(60);
        // Stall with a memory op at the pipe output and a dispatch held off
        sendOp(LANE_MEM, 5'd7, '0);
        sendOp(LANE_INT, 5'd8, 8'h01);
        idleCycles(1);
        repeat (3) begin
            driveCycle(1'b1, '{valid: 1'b1, lane: LANE_INT, activeListPtr: 5'd9, depVector: '0},
                       '0);
        end
        sendOp(LANE_INT, 5'd9, '0);
        waitDrain(20);
        // Flushed producer in flight leaves its consumer waiting
        sendOp(LANE_MEM, 5'd10, '0);
        sendOp(LANE_INT, 5'd20, 8'h01);
        driveCycle(1'b0, '{valid: 1'b1, lane: LANE_INT, activeListPtr: 5'd21, depVector: '0},
                   '{valid: 1'b1, all: 1'b0, headPtr: 5'd10, tailPtr: 5'd12});
        idleCycles(6);
        sendFlush(1'b1, '0, '0);
        waitDrain(20);
        repeat (400) randomCycle();
        idleCycles(4);
        sendFlush(1'b1, '0, '0);
        waitDrain(20);
        $display("Result: PASSED");
        $finish;
    end

endmodule
